/* logic/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

/* logic/rv_pkg.sv */
package rv_pkg;

	// major opcodes kept by the core
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		LUI    = 7'b0110111,
		JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		XOR  = 4'd2,
		OR   = 4'd3,
		AND  = 4'd4,
		SLL  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		SLT  = 4'd8,
		SLTU = 4'd9
	} alu_op_e;

	// branch funct3 encodings
	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_cond_e;

	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		EXECUTE = 2'd1,
		LOAD_WB = 2'd2
	} state_e;

	// register writeback source
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_LOAD = 2'd1,
		WB_IMM  = 2'd2,
		WB_RA   = 2'd3
	} wb_sel_e;

endpackage : rv_pkg

/* logic/rv_decode.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_decode (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_ir_load,
	input  logic [`XLEN-1:0]       i_instr,
	output rv_pkg::opcode_e        o_opcode,
	output logic [`REG_ADDR_W-1:0] o_rs1,
	output logic [`REG_ADDR_W-1:0] o_rs2,
	output logic [`REG_ADDR_W-1:0] o_rd,
	output logic [2:0]             o_funct3,
	output logic                   o_funct7_b5,
	output logic [`XLEN-1:0]       o_imm
);

	logic [`XLEN-1:0] ir_q;
	logic [`XLEN-1:0] instr;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ir_q <= '0;
		end else if (i_ir_load) begin
			ir_q <= i_instr; // captured at end of fetch
		end
	end

	// live word while fetching, held word afterwards
	assign instr = i_ir_load ? i_instr : ir_q;

	assign o_opcode    = rv_pkg::opcode_e'(instr[6:0]);
	assign o_rd        = instr[11:7];
	assign o_funct3    = instr[14:12]; // also the branch condition
	assign o_rs1       = instr[19:15];
	assign o_rs2       = instr[24:20];
	assign o_funct7_b5 = instr[30];

	always_comb begin
		case (o_opcode)
			rv_pkg::STORE: begin
				o_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			rv_pkg::BRANCH: begin
				o_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			rv_pkg::LUI: begin
				o_imm = {instr[31:12], 12'b0};
			end
			rv_pkg::JAL: begin
				o_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default: begin
				o_imm = {{20{instr[31]}}, instr[31:20]}; // I format, shamt in [4:0]
			end
		endcase
	end

endmodule : rv_decode

/* logic/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_wr_en,
	input  logic [`REG_ADDR_W-1:0] i_rs1,
	input  logic [`REG_ADDR_W-1:0] i_rs2,
	input  logic [`REG_ADDR_W-1:0] i_rd,
	input  logic [`XLEN-1:0]       i_wr_data,
	output logic [`XLEN-1:0]       o_rs1_data,
	output logic [`XLEN-1:0]       o_rs2_data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && (i_rd != '0)) begin
			regs[i_rd] <= i_wr_data; // x0 never written
		end
	end

	assign o_rs1_data = regs[i_rs1];
	assign o_rs2_data = regs[i_rs2];

	a_x0_zero : assert property (@(posedge clk) disable iff (reset)
		((i_rs1 != '0) || (o_rs1_data == '0)) && ((i_rs2 != '0) || (o_rs2_data == '0)));

endmodule : rv_regfile

/* logic/rv_alu.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_alu (
	input  rv_pkg::alu_op_e  i_op,
	input  logic [`XLEN-1:0] i_a,
	input  logic [`XLEN-1:0] i_b,
	input  logic [2:0]       i_funct3,
	output logic [`XLEN-1:0] o_result,
	output logic             o_branch_taken
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = i_b[4:0];
	assign lt_s  = $signed(i_a) < $signed(i_b);
	assign lt_u  = i_a < i_b;

	always_comb begin
		case (i_op)
			rv_pkg::ADD:  o_result = i_a + i_b;
			rv_pkg::SUB:  o_result = i_a - i_b;
			rv_pkg::XOR:  o_result = i_a ^ i_b;
			rv_pkg::OR:   o_result = i_a | i_b;
			rv_pkg::AND:  o_result = i_a & i_b;
			rv_pkg::SLL:  o_result = i_a << shamt;
			rv_pkg::SRL:  o_result = i_a >> shamt;
			rv_pkg::SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
			rv_pkg::SLT:  o_result = {{(`XLEN-1){1'b0}}, lt_s};
			rv_pkg::SLTU: o_result = {{(`XLEN-1){1'b0}}, lt_u};
			default:      o_result = i_a + i_b;
		endcase
	end

	// compare of rs1 against rs2
	always_comb begin
		case (rv_pkg::branch_cond_e'(i_funct3))
			rv_pkg::BEQ:  o_branch_taken = (i_a == i_b);
			rv_pkg::BNE:  o_branch_taken = (i_a != i_b);
			rv_pkg::BLT:  o_branch_taken = lt_s;
			rv_pkg::BGE:  o_branch_taken = !lt_s;
			rv_pkg::BLTU: o_branch_taken = lt_u;
			rv_pkg::BGEU: o_branch_taken = !lt_u;
			default:      o_branch_taken = 1'b0; // reserved encodings fall through
		endcase
	end

endmodule : rv_alu

/* logic/rv_control.sv */
`timescale 1ns/100ps

module rv_control (
	input  logic             clk,
	input  logic             reset,
	input  rv_pkg::opcode_e  i_opcode,
	input  logic [2:0]       i_funct3,
	input  logic             i_funct7_b5,
	input  logic             i_branch_taken,
	output rv_pkg::state_e   o_state,
	output logic             o_ir_load,
	output logic             o_imem_rd,
	output rv_pkg::alu_op_e  o_alu_op,
	output logic             o_use_imm,
	output logic             o_rf_wr,
	output rv_pkg::wb_sel_e  o_wb_sel,
	output logic             o_dmem_rd,
	output logic             o_dmem_wr,
	output logic             o_pc_load,
	output logic             o_pc_jump
);

	rv_pkg::state_e state_q;
	rv_pkg::state_e state_d;
	logic           run_q;

	function automatic rv_pkg::alu_op_e alu_op_for(input logic [2:0] f3, input logic f7b5,
		input logic is_reg);
		case (f3)
			3'd0:    return (is_reg && f7b5) ? rv_pkg::SUB : rv_pkg::ADD;
			3'd1:    return rv_pkg::SLL;
			3'd2:    return rv_pkg::SLT;
			3'd3:    return rv_pkg::SLTU;
			3'd4:    return rv_pkg::XOR;
			3'd5:    return f7b5 ? rv_pkg::SRA : rv_pkg::SRL; // srai carries bit 30 too
			3'd6:    return rv_pkg::OR;
			default: return rv_pkg::AND;
		endcase
	endfunction

	// one idle cycle after reset keeps the strobes quiet
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= rv_pkg::FETCH;
			run_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			run_q   <= 1'b1;
		end
	end

	assign o_state = state_q;

	always_comb begin
		state_d   = state_q;
		o_ir_load = 1'b0;
		o_imem_rd = 1'b0;
		o_alu_op  = rv_pkg::ADD;
		o_use_imm = 1'b0;
		o_rf_wr   = 1'b0;
		o_wb_sel  = rv_pkg::WB_ALU;
		o_dmem_rd = 1'b0;
		o_dmem_wr = 1'b0;
		o_pc_load = 1'b0;
		o_pc_jump = 1'b0;
		case (state_q)
			rv_pkg::FETCH: begin
				o_imem_rd = run_q;
				o_ir_load = run_q;
				state_d   = run_q ? rv_pkg::EXECUTE : rv_pkg::FETCH;
			end
			rv_pkg::EXECUTE: begin
				o_pc_load = 1'b1;
				state_d   = rv_pkg::FETCH;
				case (i_opcode)
					rv_pkg::OP: begin
						o_alu_op = alu_op_for(i_funct3, i_funct7_b5, 1'b1);
						o_rf_wr  = 1'b1;
					end
					rv_pkg::OP_IMM: begin
						o_alu_op  = alu_op_for(i_funct3, i_funct7_b5, 1'b0);
						o_use_imm = 1'b1;
						o_rf_wr   = 1'b1;
					end
					rv_pkg::LOAD: begin
						o_use_imm = 1'b1; // address = rs1 + imm
						o_dmem_rd = 1'b1;
						o_pc_load = 1'b0; // pc moves in writeback
						state_d   = rv_pkg::LOAD_WB;
					end
					rv_pkg::STORE: begin
						o_use_imm = 1'b1;
						o_dmem_wr = 1'b1;
					end
					rv_pkg::BRANCH: o_pc_jump = i_branch_taken;
					rv_pkg::LUI: begin
						o_rf_wr  = 1'b1;
						o_wb_sel = rv_pkg::WB_IMM;
					end
					rv_pkg::JAL: begin
						o_rf_wr   = 1'b1;
						o_wb_sel  = rv_pkg::WB_RA;
						o_pc_jump = 1'b1;
					end
					default: ; // unknown opcode just steps over
				endcase
			end
			rv_pkg::LOAD_WB: begin
				o_rf_wr   = 1'b1;
				o_wb_sel  = rv_pkg::WB_LOAD;
				o_pc_load = 1'b1;
				state_d   = rv_pkg::FETCH;
			end
			default: state_d = rv_pkg::FETCH;
		endcase
	end

	a_rd_wr_excl : assert property (@(posedge clk) disable iff (reset)
		!(o_dmem_rd && o_dmem_wr));

	a_state_legal : assert property (@(posedge clk) disable iff (reset)
		state_q inside {rv_pkg::FETCH, rv_pkg::EXECUTE, rv_pkg::LOAD_WB});

endmodule : rv_control

/* logic/rv_core.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_core (
	input  logic             clk,
	input  logic             reset,
	input  logic [`XLEN-1:0] i_imem_rddata,
	output logic [`XLEN-1:0] o_imem_addr,
	output logic             o_imem_rd,
	input  logic [`XLEN-1:0] i_dmem_rddata,
	output logic [`XLEN-1:0] o_dmem_addr,
	output logic             o_dmem_rd,
	output logic             o_dmem_wr,
	output logic [`XLEN-1:0] o_dmem_wrdata
);

	rv_pkg::state_e          state;
	rv_pkg::opcode_e         opcode;
	rv_pkg::alu_op_e         alu_op;
	rv_pkg::wb_sel_e         wb_sel;
	logic [`REG_ADDR_W-1:0]  rs1;
	logic [`REG_ADDR_W-1:0]  rs2;
	logic [`REG_ADDR_W-1:0]  rd;
	logic [2:0]              funct3;
	logic                    funct7_b5;
	logic [`XLEN-1:0]        imm;
	logic                    ir_load;
	logic                    use_imm;
	logic                    rf_wr;
	logic                    pc_load;
	logic                    pc_jump;
	logic                    branch_taken;
	logic [`XLEN-1:0]        pc_q;
	logic [`XLEN-1:0]        pc_plus4;
	logic [`XLEN-1:0]        pc_target;
	logic [`XLEN-1:0]        rs1_data;
	logic [`XLEN-1:0]        rs2_data;
	logic [`XLEN-1:0]        alu_b;
	logic [`XLEN-1:0]        alu_result;
	logic [`XLEN-1:0]        load_q;
	logic [`XLEN-1:0]        wb_data;

	assign pc_plus4  = pc_q + `XLEN'd4;
	assign pc_target = pc_q + imm; // branch and jal target

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc_q <= `RESET_PC;
		end else if (pc_load) begin
			pc_q <= pc_jump ? pc_target : pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (o_dmem_rd) begin
			load_q <= i_dmem_rddata; // word held for LOAD_WB
		end
	end

	assign alu_b = use_imm ? imm : rs2_data;

	always_comb begin
		case (wb_sel)
			rv_pkg::WB_LOAD: wb_data = load_q;
			rv_pkg::WB_IMM:  wb_data = imm;
			rv_pkg::WB_RA:   wb_data = pc_plus4; // link address
			default:         wb_data = alu_result;
		endcase
	end

	assign o_imem_addr   = pc_q;
	assign o_dmem_addr   = alu_result;
	assign o_dmem_wrdata = rs2_data;

	rv_control u_control (
		.clk(clk), .reset(reset), .i_opcode(opcode), .i_funct3(funct3),
		.i_funct7_b5(funct7_b5), .i_branch_taken(branch_taken), .o_state(state),
		.o_ir_load(ir_load), .o_imem_rd(o_imem_rd), .o_alu_op(alu_op), .o_use_imm(use_imm),
		.o_rf_wr(rf_wr), .o_wb_sel(wb_sel), .o_dmem_rd(o_dmem_rd), .o_dmem_wr(o_dmem_wr),
		.o_pc_load(pc_load), .o_pc_jump(pc_jump)
	);

	rv_decode u_decode (
		.clk(clk), .reset(reset), .i_ir_load(ir_load), .i_instr(i_imem_rddata),
		.o_opcode(opcode), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_funct3(funct3),
		.o_funct7_b5(funct7_b5), .o_imm(imm)
	);

	rv_regfile u_regfile (
		.clk(clk), .reset(reset), .i_wr_en(rf_wr), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
		.i_wr_data(wb_data), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

	rv_alu u_alu (
		.i_op(alu_op), .i_a(rs1_data), .i_b(alu_b), .i_funct3(funct3),
		.o_result(alu_result), .o_branch_taken(branch_taken)
	);

	a_pc_aligned : assert property (@(posedge clk) disable iff (reset)
		pc_q[1:0] == 2'b00);

	// pc only moves at the end of the last instruction cycle
	a_pc_hold_fetch : assert property (@(posedge clk) disable iff (reset)
		(state == rv_pkg::FETCH) |=> $stable(pc_q));

endmodule : rv_core

/* dv/rv_program.svh */
`ifndef RV_PROGRAM_SVH
`define RV_PROGRAM_SVH

// x1 = -7, x2 = 3, x10 result, x12 wrong-path marker, x13 correct-path marker
localparam int PROG_WORDS = 84;

localparam logic [31:0] PROGRAM [PROG_WORDS] = '{
	32'hFF900093, 32'h00300113, 32'h123451B7, 32'h0BD00613, // addi x1, x2, lui x3, x12
	32'h60D00693, 32'h10302023, 32'h00208533, 32'h10A02223, // x13, sw x3, add
	32'h40208533, 32'h10A02423, 32'h0020C533, 32'h10A02623, // sub, xor
	32'h0020E533, 32'h10A02823, 32'h0020F533, 32'h10A02A23, // or, and
	32'h00209533, 32'h10A02C23, 32'h0020D533, 32'h10A02E23, // sll, srl
	32'h4020D533, 32'h12A02023, 32'h0020A533, 32'h12A02223, // sra, slt
	32'h0020B533, 32'h12A02423, 32'hFFB08513, 32'h12A02623, // sltu, addi
	32'h0F00C513, 32'h12A02823, 32'hFF016513, 32'h12A02A23, // xori, ori
	32'h0FF0F513, 32'h12A02C23, 32'h00411513, 32'h12A02E23, // andi, slli
	32'h01C0D513, 32'h14A02023, 32'h4010D513, 32'h14A02223, // srli, srai
	32'hFF80A513, 32'h14A02423, 32'hFFF13513, 32'h14A02623, // slti, sltiu
	32'h20102023, 32'h20002583, 32'h20B02223, 32'h00500013, // sw, lw, sw, addi x0
	32'h20002423, 32'h00210463, 32'h28C02023, 32'h28D02023, // sw x0, beq taken
	32'h00208463, 32'h28D02223, 32'h00209463, 32'h28C02423, // beq not taken, bne
	32'h28D02423, 32'h00211463, 32'h28D02623, 32'h0020C463,
	32'h28C02823, 32'h28D02823, 32'h00114463, 32'h28D02A23, // blt both ways
	32'h00115463, 32'h28C02C23, 32'h28D02C23, 32'h0020D463,
	32'h28D02E23, 32'h00116463, 32'h2AC02023, 32'h2AD02023, // bge done, bltu
	32'h0020E463, 32'h2AD02223, 32'h0020F463, 32'h2AC02423,
	32'h2AD02423, 32'h00117463, 32'h2AD02623, 32'h0080076F, // bgeu, jal x14 +8
	32'h30C02023, 32'h30E02023, 32'h30D02223, 32'h0000006F  // skipped, link, target, spin
};

// test name, store address, stored word
task automatic load_expected();
	expect_store("lui", 32'h100, 32'h1234_5000);
	expect_store("add", 32'h104, 32'hFFFF_FFFC);
	expect_store("sub", 32'h108, 32'hFFFF_FFF6);
	expect_store("xor", 32'h10C, 32'hFFFF_FFFA);
	expect_store("or", 32'h110, 32'hFFFF_FFFB);
	expect_store("and", 32'h114, 32'h0000_0001);
	expect_store("sll", 32'h118, 32'hFFFF_FFC8);
	expect_store("srl", 32'h11C, 32'h1FFF_FFFF);
	expect_store("sra", 32'h120, 32'hFFFF_FFFF);
	expect_store("slt", 32'h124, 32'h0000_0001);
	expect_store("sltu", 32'h128, 32'h0000_0000);
	expect_store("addi", 32'h12C, 32'hFFFF_FFF4);
	expect_store("xori", 32'h130, 32'hFFFF_FF09);
	expect_store("ori", 32'h134, 32'hFFFF_FFF3);
	expect_store("andi", 32'h138, 32'h0000_00F9);
	expect_store("slli", 32'h13C, 32'h0000_0030);
	expect_store("srli", 32'h140, 32'h0000_000F);
	expect_store("srai", 32'h144, 32'hFFFF_FFFC);
	expect_store("slti", 32'h148, 32'h0000_0000);
	expect_store("sltiu", 32'h14C, 32'h0000_0001);
	expect_store("sw_word", 32'h200, 32'hFFFF_FFF9);
	expect_store("lw_round_trip", 32'h204, 32'hFFFF_FFF9);
	expect_store("x0_stays_zero", 32'h208, 32'h0000_0000);
	expect_store("beq_taken", 32'h280, 32'h0000_060D);
	expect_store("beq_not_taken", 32'h284, 32'h0000_060D);
	expect_store("bne_taken", 32'h288, 32'h0000_060D);
	expect_store("bne_not_taken", 32'h28C, 32'h0000_060D);
	expect_store("blt_taken", 32'h290, 32'h0000_060D);
	expect_store("blt_not_taken", 32'h294, 32'h0000_060D);
	expect_store("bge_taken", 32'h298, 32'h0000_060D);
	expect_store("bge_not_taken", 32'h29C, 32'h0000_060D);
	expect_store("bltu_taken", 32'h2A0, 32'h0000_060D);
	expect_store("bltu_not_taken", 32'h2A4, 32'h0000_060D);
	expect_store("bgeu_taken", 32'h2A8, 32'h0000_060D);
	expect_store("bgeu_not_taken", 32'h2AC, 32'h0000_060D);
	expect_store("jal_link", 32'h300, 32'h0000_0140); // jal at 0x13c
	expect_store("jal_target", 32'h304, 32'h0000_060D);
endtask

`endif

/* dv/rv_core_tb.sv */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_core_tb;

	localparam int CLK_PERIOD = 4;
	localparam int WAIT_LIMIT = 50; // cycles allowed per wait
	localparam int IMEM_WORDS = 128;
	localparam int DMEM_WORDS = 256;

	logic             clk;
	logic             reset;
	logic [`XLEN-1:0] imem_rddata;
	logic [`XLEN-1:0] imem_addr;
	logic             imem_rd;
	logic [`XLEN-1:0] dmem_rddata;
	logic [`XLEN-1:0] dmem_addr;
	logic             dmem_rd;
	logic             dmem_wr;
	logic [`XLEN-1:0] dmem_wrdata;

	logic [`XLEN-1:0] imem [IMEM_WORDS];
	logic [`XLEN-1:0] dmem [DMEM_WORDS];

	string            name_q [$];
	logic [`XLEN-1:0] addr_q [$];
	logic [`XLEN-1:0] data_q [$];

	int error_count;
	int test_count;
	int failed_count;

	task automatic expect_store(input string name, input logic [`XLEN-1:0] addr,
		input logic [`XLEN-1:0] data);
		name_q.push_back(name);
		addr_q.push_back(addr);
		data_q.push_back(data);
	endtask

	`include "rv_program.svh"

	rv_core i_dut (
		.clk(clk), .reset(reset), .i_imem_rddata(imem_rddata), .o_imem_addr(imem_addr),
		.o_imem_rd(imem_rd), .i_dmem_rddata(dmem_rddata), .o_dmem_addr(dmem_addr),
		.o_dmem_rd(dmem_rd), .o_dmem_wr(dmem_wr), .o_dmem_wrdata(dmem_wrdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// both memories answer in the same cycle
	assign imem_rddata = imem[imem_addr[8:2]];
	assign dmem_rddata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= 32'hD000_0000 | 32'(i << 2); // address tagged fill
			end
		end else if (dmem_wr) begin
			dmem[dmem_addr[9:2]] <= dmem_wrdata;
		end
	end

	task automatic check_value(input string sig, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, sig, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input bit ok);
		test_count++;
		if (!ok) begin
			failed_count++;
		end
		$display("test %0d %s: %s", test_count, name, ok ? "ok" : "mismatch");
	endtask

	task automatic wait_fetch(output bit seen, output int cycles);
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			seen = imem_rd;
		end
	endtask

	task automatic wait_store(output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			seen = dmem_wr;
		end
	endtask

	task automatic check_reset_fetch();
		bit seen;
		int cycles;
		int errs_before;
		errs_before = error_count;
		repeat (2) begin
			@(negedge clk);
			check_value("o_imem_rd", `XLEN'(imem_rd), '0); // quiet while in reset
			check_value("o_dmem_rd", `XLEN'(dmem_rd), '0);
			check_value("o_dmem_wr", `XLEN'(dmem_wr), '0);
		end
		reset = 1'b0;
		wait_fetch(seen, cycles);
		if (!seen) begin
			$display("timed out waiting for the first instruction fetch");
		end else begin
			check_value("first fetch cycle", cycles, 32'd1);
			check_value("o_imem_addr", imem_addr, `RESET_PC);
			wait_fetch(seen, cycles);
			if (!seen) begin
				$display("timed out waiting for the second instruction fetch");
			end else begin
				check_value("fetch spacing", cycles, 32'd2); // addi takes two cycles
				check_value("o_imem_addr", imem_addr, `RESET_PC + 32'd4);
			end
		end
		report_test("reset_fetch", seen && (error_count == errs_before));
	endtask

	initial begin
		bit seen;
		int errs_before;
		error_count = 0;
		test_count = 0;
		failed_count = 0;
		clk = 1'b0;
		reset = 1'b1;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = (i < PROG_WORDS) ? PROGRAM[i] : (32'(i) << 7); // opcode 0 past the end
		end
		load_expected();
		check_reset_fetch();
		for (int t = 0; t < name_q.size(); t++) begin
			wait_store(seen);
			if (!seen) begin
				$display("timed out waiting for the store of test %s", name_q[t]);
				report_test(name_q[t], 1'b0);
				break;
			end
			errs_before = error_count;
			check_value("o_dmem_addr", dmem_addr, addr_q[t]);
			check_value("o_dmem_wrdata", dmem_wrdata, data_q[t]);
			report_test(name_q[t], error_count == errs_before);
		end
		$display("%0d tests run, %0d failed, %0d check errors", test_count, failed_count,
			error_count);
		if (failed_count == 0 && error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule : rv_core_tb

/* src.f */
+incdir+logic
+incdir+dv
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_control.sv
logic/rv_core.sv
dv/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module rv_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vrv_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
exit 0
